// File: cache.f
logic/cache_pkg.sv
logic/line_store.sv
logic/plru_tree.sv
logic/cache_control.sv
logic/cache.sv
sim/cache_props.sv
sim/cache_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module cache_tb -f cache.f -o cache_sim
	./obj_dir/cache_sim +verilator+error+limit+1000 | \
		awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: sim/cache_tb.sv
`timescale 1ns/1ns

module cache_tb import cache_pkg::*; ();

    localparam int WAYS = 4;
    localparam int SETS = 16;
    localparam int SET_W = $clog2(SETS);
    localparam int RESP_TIMEOUT = 200;

    logic              clk;
    logic              rst;
    cpu_req_t          cpu_req;
    logic [LINE_W-1:0] ufp_rdata;
    logic              ufp_resp;
    mem_req_t          mem_req;
    logic [LINE_W-1:0] dfp_rdata;
    logic              dfp_resp;

    int seed = 26;
    int errors = 0;
    int checks = 0;
    int mem_reads = 0;
    int mem_writes = 0;

    // Backing memory by line address, reference words by word address
    logic [LINE_W-1:0] mem_lines [logic [ADDR_W-1:0]];
    logic [WORD_W-1:0] ref_words [logic [ADDR_W-1:0]];

    cache #(.WAYS(WAYS), .SETS(SETS)) dut_i (
        .clk, .rst, .cpu_req, .ufp_rdata, .ufp_resp,
        .mem_req, .dfp_rdata, .dfp_resp
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input int word);
        return (ADDR_W'(tag) << (OFFSET_W + SET_W)) | (ADDR_W'(set) << OFFSET_W)
            | (ADDR_W'(word) << 2);
    endfunction

    // Contents of memory that was never written
    function automatic logic [WORD_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
        return addr * 32'h9e37_79b1 + 32'h0bad_f00d;
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] key;
        key = {addr[ADDR_W-1:2], 2'b00};
        if (ref_words.exists(key)) begin
            return ref_words[key];
        end
        return fill_word(key);
    endfunction

    function automatic logic [LINE_W-1:0] memory_line(input logic [ADDR_W-1:0] line_addr);
        logic [LINE_W-1:0] line;
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = fill_word(line_addr + ADDR_W'(4 * w));
        end
        return line;
    endfunction

    // Answers each line request after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        logic [ADDR_W-1:0] line_addr;
        dfp_resp = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (mem_req.read || mem_req.write)) begin
                delay = 1 + int'($unsigned($random(seed)) % 4);
                line_addr = mem_req.addr;
                repeat (delay) @(posedge clk);
                #1;
                if (mem_req.write) begin
                    mem_lines[line_addr] = mem_req.wdata;
                    mem_writes++;
                end else begin
                    dfp_rdata = memory_line(line_addr);
                    mem_reads++;
                end
                dfp_resp = 1'b1;
                @(posedge clk);
                #1;
                dfp_resp = 1'b0;
            end
        end
    end

    // A zero wmask makes the access a read
    task automatic access_word(input logic [ADDR_W-1:0] addr, input logic [3:0] wmask,
                               input logic [WORD_W-1:0] wdata, output int latency);
        logic [WORD_W-1:0] rword;
        logic [WORD_W-1:0] merged;
        cpu_req.addr  = addr;
        cpu_req.rmask = (wmask == 4'b0) ? 4'hf : 4'b0;
        cpu_req.wmask = wmask;
        cpu_req.wdata = wdata;
        latency = 0;
        @(negedge clk);
        while (!ufp_resp && latency < RESP_TIMEOUT) begin
            @(negedge clk);
            latency++;
        end
        if (!ufp_resp) begin
            $display("timed out waiting for response at %0t, address %h", $time, addr);
            $display("ERRORS FOUND");
            $finish;
        end
        rword = ufp_rdata[addr[OFFSET_W-1:2]*WORD_W +: WORD_W];
        merged = expected_word(addr);
        if (wmask == 4'b0) begin
            checks++;
            assert (rword == merged) else begin
                errors++;
                $display("[ERROR] %0t: read %h returned %h, expected %h",
                         $time, addr, rword, merged);
            end
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    merged[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            ref_words[{addr[ADDR_W-1:2], 2'b00}] = merged;
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
    endtask

    task automatic check_count(input int got, input int expected, input string what);
        checks++;
        assert (got == expected) else begin
            errors++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %-12s %0d errors", name, errors - errors_before);
    endtask

    initial begin : stimulus
        int lat;
        int e0;
        int count_before;
        logic [31:0] r;
        logic [3:0] wmask;
        logic [ADDR_W-1:0] addr;
        logic [LINE_W-1:0] line;
        rst = 1'b1;
        cpu_req = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        for (int t = 0; t < 6; t++) begin
            access_word(make_addr(t + 1, 1, t), 4'b0, '0, lat);
        end
        report_test("fill_read", e0);

        e0 = errors;
        for (int t = 0; t < 4; t++) begin
            access_word(make_addr(t + 11, 6, 7 - t), 4'b0, '0, lat);
            access_word(make_addr(t + 11, 6, 7 - t), 4'b0, '0, lat);
            check_count(lat, 1, "repeat access latency");
        end
        report_test("repeat_hit", e0);

        // Tags A to D fill set 5, A is touched, then E should replace B
        e0 = errors;
        for (int t = 0; t < 4; t++) begin
            access_word(make_addr(32'ha1 + t, 5, 0), 4'b0, '0, lat);
        end
        access_word(make_addr(32'ha1, 5, 0), 4'b0, '0, lat);
        access_word(make_addr(32'ha5, 5, 0), 4'b0, '0, lat);
        access_word(make_addr(32'ha1, 5, 0), 4'b0, '0, lat);
        check_count(lat, 1, "latency of A after E");
        count_before = mem_reads;
        access_word(make_addr(32'ha2, 5, 0), 4'b0, '0, lat);
        check_count(mem_reads - count_before, 1, "memory reads for B");
        report_test("plru_evict", e0);

        e0 = errors;
        addr = make_addr(7, 9, 3);
        access_word(addr, 4'b0110, 32'hcafe_beef, lat);
        count_before = mem_writes;
        for (int t = 0; t < 5; t++) begin
            access_word(make_addr(20 + t, 9, 0), 4'b0, '0, lat);
        end
        check_count(mem_writes - count_before, 1, "write-backs from set 9");
        line = memory_line({addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}});
        check_count(int'(line[3*WORD_W +: WORD_W] == expected_word(addr)), 1,
                    "written word found in memory");
        for (int t = 0; t < 4; t++) begin
            access_word(make_addr(30 + t, 9, 1), 4'b0, '0, lat);
        end
        access_word(addr, 4'b0, '0, lat);
        report_test("writeback", e0);

        e0 = errors;
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            wmask = r[13:10];
            if (r[9] && wmask == 4'b0) begin
                wmask = 4'hf;
            end
            if (!r[9]) begin
                wmask = 4'b0;
            end
            addr = make_addr(40 + int'(r[3:0]), 2 + int'(r[5:4]) % 3, int'(r[8:6]));
            access_word(addr, wmask, $random(seed), lat);
        end
        report_test("random", e0);

        $display("checks %0d, errors %0d, protocol failures %0d",
                 checks, errors, dut_i.props_i.fail_count);
        if (errors == 0 && dut_i.props_i.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim/cache_props.sv
`timescale 1ns/1ns

module cache_props import cache_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     ufp_resp,
    input mem_req_t mem_req
);

    int fail_count = 0;

    one_command: assert property (@(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write))
        else begin
            fail_count++;
            $error("memory read and write both high");
        end

    line_aligned: assert property (@(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) |-> mem_req.addr[OFFSET_W-1:0] == '0)
        else begin
            fail_count++;
            $error("memory address not line-aligned");
        end

    // CPU response is a single-cycle pulse
    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else begin
            fail_count++;
            $error("ufp_resp held longer than one cycle");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !ufp_resp && !mem_req.read && !mem_req.write)
        else begin
            fail_count++;
            $error("outputs active right after reset");
        end

endmodule

bind cache cache_props props_i (
    .clk, .rst, .ufp_resp, .mem_req
);

// File: logic/cache.sv
`timescale 1ns/1ns

module cache import cache_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  cpu_req_t          cpu_req,
    output logic [LINE_W-1:0] ufp_rdata,
    output logic              ufp_resp,
    output mem_req_t          mem_req,
    input  logic [LINE_W-1:0] dfp_rdata,
    input  logic              dfp_resp
);

    localparam int SET_W = $clog2(SETS);
    localparam int TAG_W = ADDR_W - SET_W - OFFSET_W;
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    logic [SET_W-1:0]            index;
    logic [WAYS-1:0]             data_we;
    logic [WAYS-1:0]             tag_we;
    logic [WAYS-1:0]             valid_we;
    logic [WAYS-1:0]             dirty_we;
    logic [LINE_W/8-1:0]         byte_mask;
    logic [LINE_W-1:0]           line_din;
    logic [TAG_W-1:0]            tag_din;
    logic                        dirty_din;
    logic [WAYS-1:0][LINE_W-1:0] line_dout;
    logic [WAYS-1:0][TAG_W-1:0]  tag_dout;
    logic [WAYS-1:0]             valid_dout;
    logic [WAYS-1:0]             dirty_dout;
    logic                        access;
    logic [WAY_W-1:0]            access_way;
    logic [WAY_W-1:0]            victim_way;

    cache_control #(.WAYS(WAYS), .SETS(SETS)) u_control (
        .clk, .rst, .cpu_req, .ufp_rdata, .ufp_resp,
        .mem_req, .dfp_rdata, .dfp_resp,
        .index, .data_we, .tag_we, .valid_we, .dirty_we,
        .byte_mask, .line_din, .tag_din, .dirty_din,
        .line_dout, .tag_dout, .valid_dout, .dirty_dout,
        .access, .access_way, .victim_way
    );

    line_store #(.WAYS(WAYS), .SETS(SETS)) u_store (
        .clk, .rst, .index,
        .data_we, .tag_we, .valid_we, .dirty_we,
        .byte_mask, .line_din, .tag_din, .dirty_din,
        .line_dout, .tag_dout, .valid_dout, .dirty_dout
    );

    // Replacement state per set
    plru_tree #(.WAYS(WAYS), .SETS(SETS)) u_plru (
        .clk, .rst, .index,
        .access, .access_way, .victim_way
    );

endmodule

// File: logic/cache_control.sv
`timescale 1ns/1ns

module cache_control import cache_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    localparam int SET_W = $clog2(SETS),
    localparam int TAG_W = ADDR_W - SET_W - OFFSET_W,
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  cpu_req_t                    cpu_req,
    output logic [LINE_W-1:0]           ufp_rdata,
    output logic                        ufp_resp,
    output mem_req_t                    mem_req,
    input  logic [LINE_W-1:0]           dfp_rdata,
    input  logic                        dfp_resp,
    output logic [SET_W-1:0]            index,
    output logic [WAYS-1:0]             data_we,
    output logic [WAYS-1:0]             tag_we,
    output logic [WAYS-1:0]             valid_we,
    output logic [WAYS-1:0]             dirty_we,
    output logic [LINE_W/8-1:0]         byte_mask,
    output logic [LINE_W-1:0]           line_din,
    output logic [TAG_W-1:0]            tag_din,
    output logic                        dirty_din,
    input  logic [WAYS-1:0][LINE_W-1:0] line_dout,
    input  logic [WAYS-1:0][TAG_W-1:0]  tag_dout,
    input  logic [WAYS-1:0]             valid_dout,
    input  logic [WAYS-1:0]             dirty_dout,
    output logic                        access,
    output logic [WAY_W-1:0]            access_way,
    input  logic [WAY_W-1:0]            victim_way
);

    localparam int BYTES_PER_WORD = WORD_W / 8;

    cache_state_t state_q, state_d;
    cpu_req_t     req_q;
    logic [TAG_W-1:0]           req_tag;
    logic [SET_W-1:0]           req_set;
    logic [OFFSET_W-3:0]        word_sel;
    logic                       hit;
    logic [WAY_W-1:0]           hit_way;

    assign req_tag  = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_set  = req_q.addr[OFFSET_W +: SET_W];
    assign word_sel = req_q.addr[OFFSET_W-1:2];

    // Live address in idle so lookup sees the set one cycle later
    assign index = (state_q == st_idle) ? cpu_req.addr[OFFSET_W +: SET_W] : req_set;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle) begin
            req_q <= cpu_req;
        end
    end

    // Tag compare
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_dout[w] && tag_dout[w] == req_tag) begin
                hit = 1'b1;
                hit_way = WAY_W'(w);
            end
        end
    end

    always_comb begin
        state_d    = state_q;
        ufp_resp   = 1'b0;
        ufp_rdata  = line_dout[hit_way];
        mem_req    = '0;
        data_we    = '0;
        tag_we     = '0;
        valid_we   = '0;
        dirty_we   = '0;
        byte_mask  = '0;
        line_din   = '0;
        tag_din    = req_tag;
        dirty_din  = 1'b0;
        access     = 1'b0;
        access_way = hit_way;

        case (state_q)
            st_idle: begin
                if (cpu_req.rmask != '0 || cpu_req.wmask != '0) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    ufp_resp = 1'b1;
                    access   = 1'b1;
                    state_d  = st_idle;
                    if (req_q.wmask != '0) begin
                        // Word replicated, byte mask picks the slot
                        data_we[hit_way] = 1'b1;
                        line_din = {WORDS_PER_LINE{req_q.wdata}};
                        byte_mask[word_sel*BYTES_PER_WORD +: BYTES_PER_WORD] = req_q.wmask;
                        dirty_we[hit_way] = 1'b1;
                        dirty_din = 1'b1;
                    end
                end else if (dirty_dout[victim_way]) begin
                    state_d = st_writeback;
                end else begin
                    state_d = st_allocate;
                end
            end
            st_writeback: begin
                mem_req.write = 1'b1;
                mem_req.addr  = {tag_dout[victim_way], req_set, {OFFSET_W{1'b0}}};
                mem_req.wdata = line_dout[victim_way];
                if (dfp_resp) begin
                    dirty_we[victim_way] = 1'b1;
                    state_d = st_allocate;
                end
            end
            st_allocate: begin
                mem_req.read = 1'b1;
                mem_req.addr = {req_tag, req_set, {OFFSET_W{1'b0}}};
                if (dfp_resp) begin
                    data_we[victim_way]  = 1'b1;
                    tag_we[victim_way]   = 1'b1;
                    valid_we[victim_way] = 1'b1;
                    line_din  = dfp_rdata;
                    byte_mask = '1;
                    // Held request retries from idle and hits
                    state_d = st_idle;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

endmodule

// File: logic/plru_tree.sv
`timescale 1ns/1ns

module plru_tree #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    localparam int SET_W = $clog2(SETS),
    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [SET_W-1:0] index,
    input  logic             access,
    input  logic [WAY_W-1:0] access_way,
    output logic [WAY_W-1:0] victim_way
);

    localparam int LEVELS = $clog2(WAYS);

    if (WAYS == 1) begin : g_direct
        // Nothing to choose between
        assign victim_way = '0;
    end else begin : g_tree
        // Heap order: node n has children 2n+1 and 2n+2
        logic [WAYS-2:0] tree_q [SETS];
        logic [WAYS-2:0] cur_bits;
        logic [WAYS-2:0] next_bits;

        assign cur_bits = tree_q[index];

        // Follow the pointers down from the root
        always_comb begin : walk
            int node;
            node = 0;
            victim_way = '0;
            for (int l = 0; l < LEVELS; l++) begin
                victim_way[LEVELS-1-l] = cur_bits[node];
                node = 2 * node + 1 + int'(cur_bits[node]);
            end
        end

        // Point every node on the accessed path away from it
        always_comb begin : touch
            int node;
            node = 0;
            next_bits = cur_bits;
            for (int l = 0; l < LEVELS; l++) begin
                next_bits[node] = ~access_way[LEVELS-1-l];
                node = 2 * node + 1 + int'(access_way[LEVELS-1-l]);
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int s = 0; s < SETS; s++) begin
                    tree_q[s] <= '0;
                end
            end else if (access) begin
                tree_q[index] <= next_bits;
            end
        end
    end

endmodule

// File: logic/line_store.sv
`timescale 1ns/1ns

module line_store import cache_pkg::*; #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    localparam int SET_W = $clog2(SETS),
    localparam int TAG_W = ADDR_W - SET_W - OFFSET_W
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [SET_W-1:0]                  index,
    input  logic [WAYS-1:0]                   data_we,
    input  logic [WAYS-1:0]                   tag_we,
    input  logic [WAYS-1:0]                   valid_we,
    input  logic [WAYS-1:0]                   dirty_we,
    input  logic [LINE_W/8-1:0]               byte_mask,
    input  logic [LINE_W-1:0]                 line_din,
    input  logic [TAG_W-1:0]                  tag_din,
    input  logic                              dirty_din,
    output logic [WAYS-1:0][LINE_W-1:0]       line_dout,
    output logic [WAYS-1:0][TAG_W-1:0]        tag_dout,
    output logic [WAYS-1:0]                   valid_dout,
    output logic [WAYS-1:0]                   dirty_dout
);

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [LINE_W-1:0] data_mem [SETS];
        logic [TAG_W-1:0]  tag_mem [SETS];
        logic [SETS-1:0]   valid_q;
        logic [SETS-1:0]   dirty_q;
        logic [LINE_W-1:0] line_q;
        logic [TAG_W-1:0]  tag_q;
        logic              valid_rd;
        logic              dirty_rd;

        // Line storage, byte-masked write, read-before-write
        always_ff @(posedge clk) begin
            if (data_we[w]) begin
                for (int b = 0; b < LINE_W / 8; b++) begin
                    if (byte_mask[b]) begin
                        data_mem[index][b*8 +: 8] <= line_din[b*8 +: 8];
                    end
                end
            end
            line_q <= data_mem[index];
        end

        always_ff @(posedge clk) begin
            if (tag_we[w]) begin
                tag_mem[index] <= tag_din;
            end
            tag_q <= tag_mem[index];
        end

        // Status bits live in flops so they can be cleared
        always_ff @(posedge clk) begin
            if (rst) begin
                valid_q  <= '0;
                dirty_q  <= '0;
                valid_rd <= 1'b0;
                dirty_rd <= 1'b0;
            end else begin
                if (valid_we[w]) begin
                    valid_q[index] <= 1'b1;
                end
                if (dirty_we[w]) begin
                    dirty_q[index] <= dirty_din;
                end
                valid_rd <= valid_q[index];
                dirty_rd <= dirty_q[index];
            end
        end

        assign line_dout[w]  = line_q;
        assign tag_dout[w]   = tag_q;
        assign valid_dout[w] = valid_rd;
        assign dirty_dout[w] = dirty_rd;
    end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;

    // Address and line geometry
    localparam int ADDR_W = 32;
    localparam int LINE_W = 256;
    localparam int WORD_W = 32;
    localparam int OFFSET_W = 5;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_lookup    = 2'b01,
        st_writeback = 2'b10,
        st_allocate  = 2'b11
    } cache_state_t;

    // CPU side request, live while either mask is nonzero
    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [WORD_W/8-1:0] rmask;
        logic [WORD_W/8-1:0] wmask;
        logic [WORD_W-1:0]   wdata;
    } cpu_req_t;

    // Memory side request, one whole line at a time
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
        logic              write;
        logic [LINE_W-1:0] wdata;
    } mem_req_t;

endpackage
